// File: verilog/aq_bus_pkg.sv
package aq_bus_pkg;

    //////////////////////////////////////////////////
    // Bus widths
    //////////////////////////////////////////////////
    localparam int addr_w      = 16;
    localparam int data_w      = 8;
    localparam int tram_addr_w = 11;    // 2 KB text RAM
    localparam int ba_w        = 5;     // External bank address

    //////////////////////////////////////////////////
    // I/O port map
    //////////////////////////////////////////////////
    localparam logic [7:0] io_bank0    = 8'hF0;
    localparam logic [7:0] io_bank1    = 8'hF1;
    localparam logic [7:0] io_bank2    = 8'hF2;
    localparam logic [7:0] io_bank3    = 8'hF3;
    localparam logic [7:0] io_cassette = 8'hFC;
    localparam logic [7:0] io_printer  = 8'hFE;
    localparam logic [7:0] io_keyboard = 8'hFF;    // Read only

    // Paging state out of reset
    localparam logic [7:0] bank0_reset = 8'hC0;             // Page 0 with ro and overlay
    localparam logic [7:0] bank1_reset = {2'b00, 6'd33};
    localparam logic [7:0] bank2_reset = {2'b00, 6'd34};
    localparam logic [7:0] bank3_reset = {2'b00, 6'd19};

    // Overlay blocks, matched against address bits 13:11
    localparam logic [2:0] tram_block   = 3'd6;    // $3000-$37FF
    localparam logic [2:0] sysram_block = 3'd7;    // $3800-$3FFF

    // Page ranges
    localparam logic [5:0] rom_page_last  = 6'd15;
    localparam logic [5:0] ram_page_first = 6'd32;

    typedef struct packed {
        logic       ro;         // Write protect
        logic       overlay;    // Text RAM and system RAM overlay
        logic [5:0] page;       // 16 KB page number
    } bank_fields_t;

    // Same byte, raw for the bus and split for the decoder
    typedef union packed {
        logic [data_w-1:0] raw;
        bank_fields_t      fields;
    } bank_reg_t;

endpackage

// File: verilog/bus_sync.sv
`timescale 1ns/100ps

module bus_sync (
    input  logic                          sysclk,
    input  logic                          reset,
    input  logic                          bus_rd_n,
    input  logic                          bus_wr_n,
    input  logic [aq_bus_pkg::data_w-1:0] bus_wrdata,
    output logic                          bus_read,
    output logic                          bus_write,
    output logic [aq_bus_pkg::data_w-1:0] wrdata
);

    logic [2:0] rd_n_r;     // Stage 0 is the synchroniser
    logic [2:0] wr_n_r;

    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            rd_n_r <= 3'b111;   // Strobes idle high
            wr_n_r <= 3'b111;
        end else begin
            rd_n_r <= {rd_n_r[1:0], bus_rd_n};
            wr_n_r <= {wr_n_r[1:0], bus_wr_n};
        end
    end

    // One pulse per falling strobe
    assign bus_read  = rd_n_r[2:1] == 2'b10;
    assign bus_write = wr_n_r[2:1] == 2'b10;

    // Keep the newest byte while the CPU drives it
    always_ff @(posedge sysclk) begin
        if (!bus_wr_n) begin
            wrdata <= bus_wrdata;
        end
    end

endmodule

// File: verilog/mem_decode.sv
`timescale 1ns/100ps

module mem_decode (
    input  logic [aq_bus_pkg::addr_w-1:0] bus_a,
    input  logic                          bus_mreq_n,
    input  logic                          bus_wr_n,
    input  aq_bus_pkg::bank_reg_t         bank,
    output logic                          tram_sel,
    output logic                          ram_ce_n,
    output logic                          rom_ce_n,
    output logic                          ram_rom_we_n,
    output logic [aq_bus_pkg::ba_w-1:0]   ba
);

    logic       mreq;
    logic       ro;
    logic       overlay;
    logic [5:0] page;
    logic       sel_sysram;
    logic       allow_ext;      // Paged access to external memory
    logic       sel_rom;
    logic       sel_ram;
    logic       we;

    assign mreq    = !bus_mreq_n;
    assign ro      = bank.fields.ro;
    assign overlay = bank.fields.overlay;
    assign page    = bank.fields.page;

    //////////////////////////////////////////////////
    // Overlay in the 2 KB blocks at $3000 and $3800
    //////////////////////////////////////////////////
    assign tram_sel   = mreq && overlay && bus_a[13:11] == aq_bus_pkg::tram_block;
    assign sel_sysram = mreq && overlay && bus_a[13:11] == aq_bus_pkg::sysram_block;

    // Writes to a protected page go nowhere
    assign allow_ext = mreq && !tram_sel && !sel_sysram && (bus_wr_n || !ro);

    //////////////////////////////////////////////////
    // External chip selects
    //////////////////////////////////////////////////
    assign sel_rom = allow_ext && page <= aq_bus_pkg::rom_page_last;
    assign sel_ram = (allow_ext && page >= aq_bus_pkg::ram_page_first) || sel_sysram;

    // Pages 16-31 select neither chip
    assign rom_ce_n = !sel_rom;
    assign ram_ce_n = !sel_ram;

    // System RAM ignores the ro bit
    assign we           = !bus_wr_n && (sel_sysram || ((sel_ram || sel_rom) && !ro));
    assign ram_rom_we_n = !we;

    // System RAM lives at the bottom of the RAM chip
    assign ba = sel_sysram ? '0 : page[aq_bus_pkg::ba_w-1:0];

endmodule

// File: verilog/io_regs.sv
`timescale 1ns/100ps

module io_regs (
    input  logic                          sysclk,
    input  logic                          reset,
    input  logic [aq_bus_pkg::addr_w-1:0] bus_a,
    input  logic                          bus_iorq_n,
    input  logic                          bus_write,
    input  logic [aq_bus_pkg::data_w-1:0] wrdata,
    input  logic                          cassette_in,
    input  logic                          printer_in,
    input  logic [63:0]                   keys,         // Active low, byte i is row i
    output aq_bus_pkg::bank_reg_t         bank,
    output logic                          io_sel,
    output logic [aq_bus_pkg::data_w-1:0] io_rddata,
    output logic                          cassette_out,
    output logic                          printer_out
);

    logic                          iorq;
    logic [7:0]                    port;
    logic [3:0]                    sel_bank;
    logic                          sel_cassette;
    logic                          sel_printer;
    logic                          sel_keyboard;
    aq_bus_pkg::bank_reg_t         bank_r [4];
    logic [aq_bus_pkg::data_w-1:0] keyb_data;

    //////////////////////////////////////////////////
    // Port decode on the low address byte
    //////////////////////////////////////////////////
    assign iorq = !bus_iorq_n;
    assign port = bus_a[7:0];

    assign sel_bank[0]  = iorq && port == aq_bus_pkg::io_bank0;
    assign sel_bank[1]  = iorq && port == aq_bus_pkg::io_bank1;
    assign sel_bank[2]  = iorq && port == aq_bus_pkg::io_bank2;
    assign sel_bank[3]  = iorq && port == aq_bus_pkg::io_bank3;
    assign sel_cassette = iorq && port == aq_bus_pkg::io_cassette;
    assign sel_printer  = iorq && port == aq_bus_pkg::io_printer;
    assign sel_keyboard = iorq && port == aq_bus_pkg::io_keyboard;

    assign io_sel = (|sel_bank) || sel_cassette || sel_printer || sel_keyboard;

    //////////////////////////////////////////////////
    // Paging and port registers
    //////////////////////////////////////////////////
    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            bank_r[0].raw <= aq_bus_pkg::bank0_reset;
            bank_r[1].raw <= aq_bus_pkg::bank1_reset;
            bank_r[2].raw <= aq_bus_pkg::bank2_reset;
            bank_r[3].raw <= aq_bus_pkg::bank3_reset;
            cassette_out  <= 1'b0;
            printer_out   <= 1'b0;
        end else if (bus_write) begin
            for (int i = 0; i < 4; i++) begin
                if (sel_bank[i]) begin
                    bank_r[i].raw <= wrdata;
                end
            end
            if (sel_cassette) begin
                cassette_out <= wrdata[0];
            end
            if (sel_printer) begin
                printer_out <= wrdata[0];
            end
        end
    end

    // Bank for the current 16 KB quarter
    assign bank = bank_r[bus_a[15:14]];

    //////////////////////////////////////////////////
    // Keyboard scan
    //////////////////////////////////////////////////
    // A low bit in A15-A8 enables that row
    always_comb begin
        keyb_data = '1;
        for (int i = 0; i < 8; i++) begin
            if (!bus_a[8 + i]) begin
                keyb_data = keyb_data & keys[8*i +: 8];
            end
        end
    end

    // Read data, qualified by io_sel in the top level
    always_comb begin
        case (port)
            aq_bus_pkg::io_bank0:    io_rddata = bank_r[0].raw;
            aq_bus_pkg::io_bank1:    io_rddata = bank_r[1].raw;
            aq_bus_pkg::io_bank2:    io_rddata = bank_r[2].raw;
            aq_bus_pkg::io_bank3:    io_rddata = bank_r[3].raw;
            aq_bus_pkg::io_cassette: io_rddata = {7'b0, cassette_in};
            aq_bus_pkg::io_printer:  io_rddata = {7'b0, printer_in};
            aq_bus_pkg::io_keyboard: io_rddata = keyb_data;
            default:                 io_rddata = '0;
        endcase
    end

endmodule

// File: verilog/text_ram.sv
`timescale 1ns/100ps

module text_ram (
    input  logic                               sysclk,
    input  logic                               tram_sel,
    input  logic                               bus_write,
    input  logic [aq_bus_pkg::tram_addr_w-1:0] addr,
    input  logic [aq_bus_pkg::data_w-1:0]      wrdata,
    output logic [aq_bus_pkg::data_w-1:0]      rddata
);

    // 2 KB of character and attribute bytes
    logic [aq_bus_pkg::data_w-1:0] mem [0:(1 << aq_bus_pkg::tram_addr_w) - 1];

    always_ff @(posedge sysclk) begin
        if (tram_sel && bus_write) begin
            mem[addr] <= wrdata;
        end
    end

    // Registered read, one edge behind the address
    always_ff @(posedge sysclk) begin
        rddata <= mem[addr];
    end

endmodule

// File: verilog/aq_bus_top.sv
`timescale 1ns/100ps

module aq_bus_top (
    input  logic                          sysclk,
    input  logic                          reset,

    // CPU bus
    input  logic [aq_bus_pkg::addr_w-1:0] bus_a,
    input  logic [aq_bus_pkg::data_w-1:0] bus_wrdata,
    output logic [aq_bus_pkg::data_w-1:0] bus_rddata,
    output logic                          bus_rddata_en,
    input  logic                          bus_rd_n,
    input  logic                          bus_wr_n,
    input  logic                          bus_mreq_n,
    input  logic                          bus_iorq_n,

    // External memory
    output logic                          ram_ce_n,
    output logic                          rom_ce_n,
    output logic                          ram_rom_we_n,
    output logic [aq_bus_pkg::ba_w-1:0]   ba,

    // Ports
    input  logic                          cassette_in,
    output logic                          cassette_out,
    input  logic                          printer_in,
    output logic                          printer_out,
    input  logic [63:0]                   keys
);

    logic                          bus_write;
    logic [aq_bus_pkg::data_w-1:0] wrdata;
    aq_bus_pkg::bank_reg_t         bank;
    logic                          io_sel;
    logic [aq_bus_pkg::data_w-1:0] io_rddata;
    logic                          tram_sel;
    logic [aq_bus_pkg::data_w-1:0] tram_rddata;

    //////////////////////////////////////////////////
    // Strobe synchronisation
    //////////////////////////////////////////////////
    bus_sync u_bus_sync (
        .sysclk(sysclk),
        .reset(reset),
        .bus_rd_n(bus_rd_n),
        .bus_wr_n(bus_wr_n),
        .bus_wrdata(bus_wrdata),
        .bus_read(),                // No read side effects left
        .bus_write(bus_write),
        .wrdata(wrdata)
    );

    io_regs u_io_regs (
        .sysclk(sysclk),
        .reset(reset),
        .bus_a(bus_a),
        .bus_iorq_n(bus_iorq_n),
        .bus_write(bus_write),
        .wrdata(wrdata),
        .cassette_in(cassette_in),
        .printer_in(printer_in),
        .keys(keys),
        .bank(bank),
        .io_sel(io_sel),
        .io_rddata(io_rddata),
        .cassette_out(cassette_out),
        .printer_out(printer_out)
    );

    mem_decode u_mem_decode (
        .bus_a(bus_a),
        .bus_mreq_n(bus_mreq_n),
        .bus_wr_n(bus_wr_n),
        .bank(bank),
        .tram_sel(tram_sel),
        .ram_ce_n(ram_ce_n),
        .rom_ce_n(rom_ce_n),
        .ram_rom_we_n(ram_rom_we_n),
        .ba(ba)
    );

    text_ram u_text_ram (
        .sysclk(sysclk),
        .tram_sel(tram_sel),
        .bus_write(bus_write),
        .addr(bus_a[aq_bus_pkg::tram_addr_w-1:0]),
        .wrdata(wrdata),
        .rddata(tram_rddata)
    );

    //////////////////////////////////////////////////
    // Read data onto the CPU bus
    //////////////////////////////////////////////////
    always_comb begin
        if (tram_sel) begin
            bus_rddata = tram_rddata;       // $3000-$37FF
        end else if (io_sel) begin
            bus_rddata = io_rddata;
        end else begin
            bus_rddata = '0;
        end
    end

    // Drive only while an internal target answers
    assign bus_rddata_en = !bus_rd_n && (tram_sel || io_sel);

endmodule

// File: tb/aq_bus_asserts.sv
`timescale 1ns/100ps

module aq_bus_asserts (
    input logic sysclk,
    input logic reset,
    input logic bus_rd_n,
    input logic bus_wr_n,
    input logic bus_rddata_en,
    input logic ram_ce_n,
    input logic rom_ce_n,
    input logic ram_rom_we_n,
    input logic cassette_out
);

    //////////////////////////////////////////////////
    // External memory
    //////////////////////////////////////////////////
    one_chip_select: assert property (@(posedge sysclk) !(!ram_ce_n && !rom_ce_n))
        else $error("ram_ce_n and rom_ce_n are both low");

    we_needs_write: assert property (@(posedge sysclk) !ram_rom_we_n |-> !bus_wr_n)
        else $error("ram_rom_we_n is low outside a write");

    // Read bus only driven in a read
    rddata_en_in_read: assert property (@(posedge sysclk) bus_rddata_en |-> !bus_rd_n)
        else $error("bus_rddata_en is high while bus_rd_n is high");

    cassette_reset: assert property (@(posedge sysclk) reset |-> !cassette_out)
        else $error("cassette_out is high during reset");

endmodule

bind aq_bus_top aq_bus_asserts u_aq_bus_asserts (
    .sysclk(sysclk),
    .reset(reset),
    .bus_rd_n(bus_rd_n),
    .bus_wr_n(bus_wr_n),
    .bus_rddata_en(bus_rddata_en),
    .ram_ce_n(ram_ce_n),
    .rom_ce_n(rom_ce_n),
    .ram_rom_we_n(ram_rom_we_n),
    .cassette_out(cassette_out)
);

// File: tb/tb_aq_bus.sv
`timescale 1ns/100ps

module tb_aq_bus;

    localparam int          half_period   = 20;     // 40 ns sysclk
    localparam int          reset_cycles  = 5;
    localparam int          strobe_cycles = 4;
    localparam int          sample_edge   = 3;
    localparam int          wait_limit    = 16;
    localparam logic [15:0] lfsr_seed     = 16'd30717;

    logic                          sysclk, reset;
    logic [aq_bus_pkg::addr_w-1:0] bus_a;
    logic [aq_bus_pkg::data_w-1:0] bus_wrdata, bus_rddata;
    logic                          bus_rddata_en, bus_rd_n, bus_wr_n, bus_mreq_n, bus_iorq_n;
    logic                          ram_ce_n, rom_ce_n, ram_rom_we_n;
    logic [aq_bus_pkg::ba_w-1:0]   ba;
    logic                          cassette_in, cassette_out, printer_in, printer_out;
    logic [63:0]                   keys;

    // Taken on the sample edge of each bus cycle
    logic [aq_bus_pkg::data_w-1:0] seen_rddata;
    logic                          seen_en;
    logic [2:0]                    seen_ctrl;      // {ram_ce_n, rom_ce_n, ram_rom_we_n}
    logic [aq_bus_pkg::ba_w-1:0]   seen_ba;
    logic [15:0]                   lfsr;

    aq_bus_top DUT (.*);

    always #half_period sysclk = ~sysclk;

    //////////////////////////////////////////////////
    // Random bits and error reporting
    //////////////////////////////////////////////////
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 16'hB400 : lfsr >> 1;   // Taps 16,14,13,11
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_byte(input string name, input logic [aq_bus_pkg::data_w-1:0] got,
                              input logic [aq_bus_pkg::data_w-1:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("ERROR %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_bank(input string name, input aq_bus_pkg::bank_reg_t got,
                              input aq_bus_pkg::bank_reg_t exp);
        if (got.raw !== exp.raw) begin
            stop_on_error($sformatf("ERROR %s: got %h (ro %h overlay %h page %h), %s",
                name, got.raw, got.fields.ro, got.fields.overlay, got.fields.page,
                $sformatf("expected %h (ro %h overlay %h page %h)", exp.raw,
                exp.fields.ro, exp.fields.overlay, exp.fields.page)));
        end
    endtask

    task automatic check_ctrl(input string name, input logic [2:0] got, input logic [2:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("ERROR %s {ram_ce_n, rom_ce_n, we_n}: got %h, expected %h",
                name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("ERROR %s: got %h, expected %h", name, got, exp));
        end
    endtask

    //////////////////////////////////////////////////
    // Bus cycles, entered 2 ns after a rising edge
    //////////////////////////////////////////////////
    task automatic bus_cycle(input logic [15:0] addr, input logic [7:0] data,
                             input logic is_io, input logic is_write);
        bus_a      = addr;
        bus_wrdata = data;
        bus_iorq_n = !is_io;
        bus_mreq_n = is_io;
        bus_rd_n   = is_write;
        bus_wr_n   = !is_write;
        repeat (sample_edge) @(posedge sysclk);
        #1;
        seen_rddata = bus_rddata;
        seen_en     = bus_rddata_en;
        seen_ctrl   = {ram_ce_n, rom_ce_n, ram_rom_we_n};
        seen_ba     = ba;
        repeat (strobe_cycles - sample_edge) @(posedge sysclk);
        #2;
        {bus_rd_n, bus_wr_n, bus_mreq_n, bus_iorq_n} = 4'hF;
        @(posedge sysclk);      // Idle cycle so the next strobe edge is seen
        #2;
    endtask

    task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
        bus_cycle(addr, data, 1'b1, 1'b1);
    endtask

    task automatic io_read(input logic [15:0] addr);
        bus_cycle(addr, 8'h00, 1'b1, 1'b0);
    endtask

    task automatic mem_write(input logic [15:0] addr, input logic [7:0] data);
        bus_cycle(addr, data, 1'b0, 1'b1);
    endtask

    task automatic mem_read(input logic [15:0] addr);
        bus_cycle(addr, 8'h00, 1'b0, 1'b0);
    endtask

    task automatic wait_port_outputs(input logic cas, input logic prn);
        int n;
        n = 0;
        while ((cassette_out !== cas || printer_out !== prn) && n < wait_limit) begin
            @(posedge sysclk);
            #2;
            n++;
        end
        if (cassette_out !== cas || printer_out !== prn) begin
            stop_on_error("Timed out waiting for cassette_out and printer_out to change");
        end
    endtask

    // Chip selects for an access that is neither protected nor overlaid
    function automatic logic [2:0] paged_ctrl(input logic [5:0] page, input logic write);
        if (page < 6'd16) return {2'b10, !write};
        if (page >= 6'd32) return {2'b01, !write};
        return 3'b111;
    endfunction

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////
    task automatic reset_values();
        logic [7:0] exp_reset [4];
        exp_reset = '{8'hC0, 8'h21, 8'h22, 8'h13};
        check_bit("cassette_out", cassette_out, 1'b0);
        check_bit("printer_out", printer_out, 1'b0);
        for (int q = 0; q < 4; q++) begin
            io_read({8'h00, 8'hF0 + 8'(q)});
            check_bank($sformatf("bank%0d", q), seen_rddata, exp_reset[q]);
            check_bit("bus_rddata_en", seen_en, 1'b1);
        end
    endtask

    task automatic paging_decode();
        logic [5:0]  page [4];
        logic [13:0] offset;
        page[0] = 6'(rand_bits(4));             // ROM
        page[1] = 6'd16 + 6'(rand_bits(4));     // Unmapped
        page[2] = 6'd32 + 6'(rand_bits(5));     // RAM
        page[3] = 6'(rand_bits(6));
        for (int q = 0; q < 4; q++) begin
            io_write({8'h00, 8'hF0 + 8'(q)}, {2'b00, page[q]});
        end
        for (int q = 0; q < 4; q++) begin
            io_read({8'h00, 8'hF0 + 8'(q)});
            check_bank($sformatf("bank%0d", q), seen_rddata, {2'b00, page[q]});
            offset = 14'(rand_bits(14));
            mem_read({2'(q), offset});
            check_ctrl("paged read", seen_ctrl, paged_ctrl(page[q], 1'b0));
            check_byte("ba", {3'b000, seen_ba}, {3'b000, page[q][4:0]});
            check_bit("bus_rddata_en", seen_en, 1'b0);
            mem_write({2'(q), offset}, 8'(rand_bits(8)));
            check_ctrl("paged write", seen_ctrl, paged_ctrl(page[q], 1'b1));
        end
    endtask

    task automatic write_protect();
        io_write(16'h00F1, {2'b10, 6'(rand_bits(4))});
        io_write(16'h00F2, {2'b10, 6'd32 + 6'(rand_bits(5))});
        mem_write({2'b01, 14'(rand_bits(14))}, 8'hA5);
        check_ctrl("ro ROM write", seen_ctrl, 3'b111);
        mem_write({2'b10, 14'(rand_bits(14))}, 8'h5A);
        check_ctrl("ro RAM write", seen_ctrl, 3'b111);
        mem_read({2'b01, 14'(rand_bits(14))});
        check_ctrl("ro ROM read", seen_ctrl, 3'b101);    // Reads still allowed
        // System RAM at $3800 ignores ro
        io_write(16'h00F0, {2'b11, 6'(rand_bits(6))});
        mem_write({5'b00111, 11'(rand_bits(11))}, 8'h3C);
        check_ctrl("system RAM write", seen_ctrl, 3'b010);
        check_byte("ba", {3'b000, seen_ba}, 8'h00);
    endtask

    task automatic text_ram_overlay();
        logic [7:0]  model [int];
        logic [10:0] addr_q [$];
        logic [10:0] offset;
        logic [7:0]  data;
        io_write(16'h00F0, {1'(rand_bits(1)), 1'b1, 6'(rand_bits(6))});
        for (int i = 0; i < 24; i++) begin
            offset = 11'(rand_bits(11));
            data   = 8'(rand_bits(8));
            mem_write({5'b00110, offset}, data);
            check_ctrl("text RAM write", seen_ctrl, 3'b111);
            model[int'(offset)] = data;
            addr_q.push_back(offset);
        end
        foreach (addr_q[i]) begin
            mem_read({5'b00110, addr_q[i]});
            check_byte("bus_rddata", seen_rddata, model[int'(addr_q[i])]);
            check_bit("bus_rddata_en", seen_en, 1'b1);
            check_ctrl("text RAM read", seen_ctrl, 3'b111);
        end
    endtask

    task automatic port_bits();
        io_write(16'h00FC, {7'(rand_bits(7)), 1'b1});
        io_write(16'h00FE, {7'(rand_bits(7)), 1'b1});
        wait_port_outputs(1'b1, 1'b1);
        io_write(16'h00FC, {7'(rand_bits(7)), 1'b0});
        wait_port_outputs(1'b0, 1'b1);
        io_write(16'h00FE, 8'h00);
        wait_port_outputs(1'b0, 1'b0);
        for (int i = 0; i < 4; i++) begin
            cassette_in = 1'(rand_bits(1));
            printer_in  = 1'(rand_bits(1));
            io_read(16'h00FC);
            check_byte("cassette port", seen_rddata, {7'b0, cassette_in});
            io_read(16'h00FE);
            check_byte("printer port", seen_rddata, {7'b0, printer_in});
        end
    endtask

    task automatic keyboard_scan();
        logic [7:0] high;
        logic [7:0] exp;
        for (int i = 0; i < 16; i++) begin
            if (i % 4 == 0) keys = rand_bits(64);
            high = (i == 0) ? 8'hFF : 8'(rand_bits(8));   // First pass selects no row
            exp = 8'hFF;
            for (int r = 0; r < 8; r++) begin
                if (!high[r]) exp = exp & keys[8*r +: 8];
            end
            io_read({high, 8'hFF});
            check_byte("keyboard", seen_rddata, exp);
        end
    endtask

    initial begin
        lfsr        = lfsr_seed;
        sysclk      = 1'b0;
        reset       = 1'b1;
        bus_a       = '0;
        bus_wrdata  = '0;
        {bus_rd_n, bus_wr_n, bus_mreq_n, bus_iorq_n} = 4'hF;
        cassette_in = 1'b0;
        printer_in  = 1'b0;
        keys        = '1;
        repeat (reset_cycles) @(posedge sysclk);
        #2;
        reset = 1'b0;
        @(posedge sysclk);
        #2;
        reset_values();
        paging_decode();
        write_protect();
        text_ram_overlay();
        port_bits();
        keyboard_scan();
        $display("** PASS **");
        $finish;
    end

endmodule

// File: src.f
verilog/aq_bus_pkg.sv
verilog/bus_sync.sv
verilog/mem_decode.sv
verilog/io_regs.sv
verilog/text_ram.sv
verilog/aq_bus_top.sv
tb/aq_bus_asserts.sv
tb/tb_aq_bus.sv

// File: Makefile
TOP = tb_aq_bus

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '\*\* PASS \*\*'

clean:
	rm -rf obj_dir
